/* verilog/ghtPkg.sv */
// Global history predictor definitions
package ghtPkg;

    // table geometry
    localparam int BANK_COUNT   = 8;
    localparam int ROW_COUNT    = 32;
    localparam int COLUMN_COUNT = 256;

    // one row cleared per cycle after reset
    localparam int INIT_CYCLES  = ROW_COUNT;

    typedef logic [15:0] ipBits_t;
    typedef logic [7:0]  history_t;
    typedef logic [15:0] tableIndex_t;
    typedef logic [1:0]  counter_t;
    typedef logic [2:0]  bankId_t;
    typedef logic [4:0]  rowId_t;
    typedef logic [7:0]  columnId_t;
    typedef logic [2*COLUMN_COUNT-1:0] counterRow_t;

    typedef struct packed {
        bankId_t   bank;
        rowId_t    row;
        columnId_t column;
    } ghtIndex_t;

    // one update port
    typedef struct packed {
        logic        valid;
        tableIndex_t index;
        counter_t    counter;
    } ghtUpdate_t;

    // command to a single bank
    typedef struct packed {
        logic      writeEn;
        logic      clearEn;
        rowId_t    row;
        columnId_t column;
        counter_t  counter;
    } ghtBankWrite_t;

    typedef struct packed {
        logic     valid;
        logic     taken;
        counter_t counter;
    } ghtPrediction_t;

    // bank from index bits 7:6 and 0, row from 5:1, column from 15:8
    function automatic ghtIndex_t splitIndex(input tableIndex_t idx);
        ghtIndex_t result;
        result.bank   = {idx[7:6], idx[0]};
        result.row    = idx[5:1];
        result.column = idx[15:8];
        return result;
    endfunction

endpackage

/* verilog/ghtIndexHash.sv */
// Lookup index hashing
`timescale 1ns/1ns

module ghtIndexHash import ghtPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      lookupValid,
    input  ipBits_t   ipBits,
    input  history_t  history,
    output logic      indexValid,
    output ghtIndex_t lookupIndex
);

    tableIndex_t hashedIndex;

    // history folds into the upper address byte only
    assign hashedIndex = ipBits ^ {history, 8'h00};

    always_ff @(posedge clk) begin
        if (rst) begin
            indexValid <= 1'b0;
        end else begin
            indexValid <= lookupValid;
        end
    end

    // index payload follows every cycle
    always_ff @(posedge clk) begin
        lookupIndex <= splitIndex(hashedIndex);
    end

endmodule

/* verilog/ghtBank.sv */
// Counter storage bank
`timescale 1ns/1ns

module ghtBank import ghtPkg::*; (
    input  logic          clk,
    input  ghtBankWrite_t bankWrite,
    input  rowId_t        readRow,
    output counterRow_t   rowData
);

    counterRow_t rows [ROW_COUNT];

    // clear wins over write, though the arbiter never issues both
    always_ff @(posedge clk) begin
        if (bankWrite.clearEn) begin
            rows[bankWrite.row] <= '0;
        end else if (bankWrite.writeEn) begin
            rows[bankWrite.row][{bankWrite.column, 1'b0} +: 2] <= bankWrite.counter;
        end
    end

    // read sees the array before this edge's write
    assign rowData = rows[readRow];

    assert property (@(posedge clk)
        (bankWrite.writeEn || bankWrite.clearEn) |-> !$isunknown(bankWrite.row));

endmodule

/* verilog/ghtWriteArbiter.sv */
// Update port arbitration and clear sweep
`timescale 1ns/1ns

module ghtWriteArbiter import ghtPkg::*; (
    input  logic                            clk,
    input  logic                            rst,
    input  ghtUpdate_t                      update0,
    input  ghtUpdate_t                      update1,
    output logic                            updateReady,
    output ghtBankWrite_t [BANK_COUNT-1:0] bankWrite
);

    rowId_t     initCount;
    logic       initActive;
    ghtUpdate_t savedUpdate;
    logic       saveOccupied;

    ghtIndex_t  dec0;
    ghtIndex_t  dec1;
    ghtIndex_t  decSaved;
    logic       accept0;
    logic       accept1;
    logic       saveLoad;

    logic [BANK_COUNT-1:0] writeEnVec;
    logic [BANK_COUNT-1:0] clearEnVec;

    function automatic ghtBankWrite_t writeCmd(input ghtIndex_t dec, input counter_t value);
        ghtBankWrite_t cmd;
        cmd         = '0;
        cmd.writeEn = 1'b1;
        cmd.row     = dec.row;
        cmd.column  = dec.column;
        cmd.counter = value;
        return cmd;
    endfunction

    assign dec0     = splitIndex(update0.index);
    assign dec1     = splitIndex(update1.index);
    assign decSaved = splitIndex(savedUpdate.index);

    assign updateReady = !initActive && !saveOccupied;
    assign accept0     = update0.valid && updateReady;
    assign accept1     = update1.valid && updateReady;

    // same bank on both ports, port 1 waits a cycle
    assign saveLoad = accept0 && accept1 && (dec0.bank == dec1.bank);

    always_comb begin
        for (int b = 0; b < BANK_COUNT; b++) begin
            bankWrite[b] = '0;
            if (initActive) begin
                bankWrite[b].clearEn = !rst;
                bankWrite[b].row     = initCount;
            end else if (saveOccupied && decSaved.bank == bankId_t'(b)) begin
                bankWrite[b] = writeCmd(decSaved, savedUpdate.counter);
            end else if (accept0 && dec0.bank == bankId_t'(b)) begin
                bankWrite[b] = writeCmd(dec0, update0.counter);
            end else if (accept1 && dec1.bank == bankId_t'(b)) begin
                bankWrite[b] = writeCmd(dec1, update1.counter);
            end
        end
    end

    always_comb begin
        for (int b = 0; b < BANK_COUNT; b++) begin
            writeEnVec[b] = bankWrite[b].writeEn;
            clearEnVec[b] = bankWrite[b].clearEn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            initActive   <= 1'b1;
            initCount    <= '0;
            saveOccupied <= 1'b0;
        end else begin
            if (initActive) begin
                initCount <= initCount + 1'b1;
                if (initCount == rowId_t'(INIT_CYCLES - 1)) begin
                    initActive <= 1'b0;
                end
            end
            saveOccupied <= saveLoad;
        end
    end

    always_ff @(posedge clk) begin
        if (saveLoad) begin
            savedUpdate <= update1;
        end
    end

    // a bank never sees a write and a clear together
    assert property (@(posedge clk) disable iff (rst)
        (writeEnVec & clearEnVec) == '0);

    assert property (@(posedge clk) disable iff (rst)
        saveOccupied |-> !saveLoad);

    // while not ready, only the saved update may reach a bank
    assert property (@(posedge clk) disable iff (rst)
        !updateReady |-> $countones(writeEnVec) == int'(saveOccupied));

endmodule

/* verilog/ghtPredictSelect.sv */
// Counter selection and prediction register
`timescale 1ns/1ns

module ghtPredictSelect import ghtPkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          indexValid,
    input  ghtIndex_t                     lookupIndex,
    input  counterRow_t [BANK_COUNT-1:0] bankRows,
    output ghtPrediction_t                prediction
);

    counterRow_t selRow;
    counter_t    selCounter;

    // bank first, then the column within the row
    assign selRow     = bankRows[lookupIndex.bank];
    assign selCounter = selRow[{lookupIndex.column, 1'b0} +: 2];

    always_ff @(posedge clk) begin
        if (rst) begin
            prediction.valid <= 1'b0;
        end else begin
            prediction.valid <= indexValid;
        end
    end

    // upper counter bit is the direction
    always_ff @(posedge clk) begin
        prediction.taken   <= selCounter[1];
        prediction.counter <= selCounter;
    end

endmodule

/* verilog/ghtPredictor.sv */
// Global history branch predictor top
`timescale 1ns/1ns

module ghtPredictor import ghtPkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  logic           lookupValid,
    input  ipBits_t        ipBits,
    input  history_t       history,
    input  ghtUpdate_t     update0,
    input  ghtUpdate_t     update1,
    output logic           updateReady,
    output ghtPrediction_t prediction
);

    logic                            indexValid;
    ghtIndex_t                       lookupIndex;
    ghtBankWrite_t [BANK_COUNT-1:0] bankWrite;
    counterRow_t   [BANK_COUNT-1:0] bankRows;

    // index decode
    ghtIndexHash u_indexHash (
        .clk         (clk),
        .rst         (rst),
        .lookupValid (lookupValid),
        .ipBits      (ipBits),
        .history     (history),
        .indexValid  (indexValid),
        .lookupIndex (lookupIndex)
    );

    ghtWriteArbiter u_writeArbiter (
        .clk         (clk),
        .rst         (rst),
        .update0     (update0),
        .update1     (update1),
        .updateReady (updateReady),
        .bankWrite   (bankWrite)
    );

    // all banks read the same row, selection picks one later
    for (genvar b = 0; b < BANK_COUNT; b++) begin : gBank
        ghtBank u_bank (
            .clk       (clk),
            .bankWrite (bankWrite[b]),
            .readRow   (lookupIndex.row),
            .rowData   (bankRows[b])
        );
    end

    ghtPredictSelect u_predictSelect (
        .clk         (clk),
        .rst         (rst),
        .indexValid  (indexValid),
        .lookupIndex (lookupIndex),
        .bankRows    (bankRows),
        .prediction  (prediction)
    );

endmodule

/* tb/ghtTbModel.svh */
// Predictor testbench reference model
`ifndef GHT_TB_MODEL_SVH
`define GHT_TB_MODEL_SVH

localparam int RESET_CYCLES  = 10;
localparam int SWEEP_ROWS    = 32;
localparam int TABLE_SIZE    = 65536;
localparam int RANDOM_CYCLES = 520;

// directed tests plus the random mix come to about 700 cycles
localparam int TIMEOUT_CYCLES = 2000;

// one counter per full 16-bit index, bank, row and column together
counter_t modelTable [TABLE_SIZE];

logic [31:0] lcgState = 32'd47;

function automatic logic [15:0] nextRandom();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState[31:16];
endfunction

// history goes into the upper address byte
function automatic tableIndex_t hashIndex(input ipBits_t ip, input history_t hist);
    return ip ^ {hist, 8'h00};
endfunction

// bank bits are 7:6 and 0
function automatic logic [2:0] bankOf(input tableIndex_t idx);
    return {idx[7:6], idx[0]};
endfunction

// keep the bank of base, new row and column from r
function automatic tableIndex_t sameBankIndex(input tableIndex_t base, input logic [15:0] r);
    return {r[15:8], base[7:6], r[5:1], base[0]};
endfunction

`endif

/* tb/ghtPredictorTb.sv */
// Branch predictor testbench
`timescale 1ns/1ns

module ghtPredictorTb import ghtPkg::*; ();

    `include "ghtTbModel.svh"

    logic           clk = 1'b0;
    logic           rst;
    logic           lookupValid;
    ipBits_t        ipBits;
    history_t       history;
    ghtUpdate_t     update0;
    ghtUpdate_t     update1;
    logic           updateReady;
    ghtPrediction_t prediction;

    int          sweepCount = 0;
    logic        slotBusy = 1'b0;
    tableIndex_t slotIndex;
    counter_t    slotCounter;
    logic        stage1 = 1'b0;
    logic        stage2 = 1'b0;
    counter_t    expHead;
    counter_t    expQueue [$];
    logic        expReady;
    int          cycleCount = 0;
    tableIndex_t hotPool [16];

    always #4 clk = ~clk;

    ghtPredictor u_dut (
        .clk         (clk),
        .rst         (rst),
        .lookupValid (lookupValid),
        .ipBits      (ipBits),
        .history     (history),
        .update0     (update0),
        .update1     (update1),
        .updateReady (updateReady),
        .prediction  (prediction)
    );

    assign expReady = (sweepCount == SWEEP_ROWS) && !slotBusy;

    // reference model, one step per clock edge
    always @(posedge clk) begin
        if (rst) begin
            sweepCount <= 0;
            slotBusy   <= 1'b0;
            stage1     <= 1'b0;
            stage2     <= 1'b0;
        end else begin
            if (sweepCount < SWEEP_ROWS) begin
                sweepCount <= sweepCount + 1;
            end
            if (slotBusy) begin
                modelTable[slotIndex] = slotCounter;
                slotBusy <= 1'b0;
            end else if (expReady) begin
                if (update0.valid) begin
                    modelTable[update0.index] = update0.counter;
                end
                if (update1.valid) begin
                    if (update0.valid && bankOf(update0.index) == bankOf(update1.index)) begin
                        slotBusy    <= 1'b1;
                        slotIndex   <= update1.index;
                        slotCounter <= update1.counter;
                    end else begin
                        modelTable[update1.index] = update1.counter;
                    end
                end
            end
            if (stage1) begin
                expHead <= expQueue.pop_front();
            end
            // expected value includes this edge's writes
            if (lookupValid) begin
                expQueue.push_back(modelTable[hashIndex(ipBits, history)]);
            end
            stage1 <= lookupValid;
            stage2 <= stage1;
        end
    end

    readyCheck: assert property (@(posedge clk) disable iff (rst) updateReady == expReady)
        else valueError($sformatf("updateReady is %b, expected %b",
            $sampled(updateReady), $sampled(expReady)));

    validCheck: assert property (@(posedge clk) disable iff (rst) prediction.valid == stage2)
        else valueError($sformatf("prediction.valid is %b, expected %b",
            $sampled(prediction.valid), $sampled(stage2)));

    counterCheck: assert property (@(posedge clk) disable iff (rst)
        stage2 |-> prediction.counter == expHead)
        else valueError($sformatf("prediction.counter is %0d, expected %0d",
            $sampled(prediction.counter), $sampled(expHead)));

    takenCheck: assert property (@(posedge clk) disable iff (rst)
        stage2 |-> prediction.taken == expHead[1])
        else valueError($sformatf("prediction.taken is %b, expected %b",
            $sampled(prediction.taken), $sampled(expHead[1])));

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
            stopFailed();
        end
    end

    task automatic stopFailed();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic valueError(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        stopFailed();
    endtask

    function automatic ghtUpdate_t makeUpdate(input tableIndex_t idx, input counter_t value);
        ghtUpdate_t u;
        u.valid   = 1'b1;
        u.index   = idx;
        u.counter = value;
        return u;
    endfunction

    function automatic tableIndex_t pickHot();
        logic [15:0] r;
        r = nextRandom();
        return hotPool[r[3:0]];
    endfunction

    // random history, address chosen so the hash lands on idx
    task automatic driveLookup(input tableIndex_t idx);
        history_t hist;
        hist        = history_t'(nextRandom());
        history     = hist;
        ipBits      = idx ^ {hist, 8'h00};
        lookupValid = 1'b1;
    endtask

    task automatic lookupAt(input tableIndex_t idx);
        driveLookup(idx);
        @(negedge clk);
        lookupValid = 1'b0;
    endtask

    task automatic sendUpdates(input ghtUpdate_t u0, input ghtUpdate_t u1);
        while (!updateReady) begin
            @(negedge clk);
        end
        update0 = u0;
        update1 = u1;
        @(negedge clk);
        update0 = '0;
        update1 = '0;
    endtask

    initial begin
        ghtUpdate_t  u0;
        ghtUpdate_t  u1;
        logic        offerTaken;
        logic [15:0] r;
        tableIndex_t a;
        tableIndex_t b;

        rst         = 1'b1;
        lookupValid = 1'b0;
        ipBits      = '0;
        history     = '0;
        update0     = '0;
        update1     = '0;
        foreach (modelTable[i]) begin
            modelTable[i] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        while (!updateReady) begin
            @(negedge clk);
        end

        // freshly cleared table
        for (int i = 0; i < 16; i++) begin
            driveLookup(nextRandom());
            @(negedge clk);
        end
        lookupValid = 1'b0;

        // single update then lookup, all four counter values
        for (int i = 0; i < 16; i++) begin
            a = nextRandom();
            sendUpdates(makeUpdate(a, counter_t'(i)), '0);
            lookupAt(a);
        end

        // dual updates, different banks
        for (int i = 0; i < 8; i++) begin
            a = nextRandom();
            b = nextRandom();
            while (bankOf(b) == bankOf(a)) begin
                b = nextRandom();
            end
            sendUpdates(makeUpdate(a, counter_t'(i)), makeUpdate(b, counter_t'(i + 1)));
            lookupAt(a);
            lookupAt(b);
        end

        // same bank, odd passes reuse the full index
        for (int i = 0; i < 8; i++) begin
            a = nextRandom();
            b = (i % 2 == 1) ? a : sameBankIndex(a, nextRandom());
            sendUpdates(makeUpdate(a, counter_t'(i)), makeUpdate(b, counter_t'(~i)));
            lookupAt(a);
            lookupAt(b);
        end

        foreach (hotPool[k]) begin
            hotPool[k] = nextRandom();
        end
        offerTaken = 1'b1;
        u0         = '0;
        u1         = '0;
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            if (offerTaken) begin
                r        = nextRandom();
                u0       = makeUpdate(pickHot(), counter_t'(r[1:0]));
                u0.valid = r[2] | r[3];
                u1       = makeUpdate(pickHot(), counter_t'(r[5:4]));
                u1.valid = r[6];
            end
            update0 = u0;
            update1 = u1;
            // an offer made while not ready stays on the ports
            offerTaken = updateReady;
            r = nextRandom();
            if (r[1:0] != 2'b00) begin
                driveLookup(pickHot());
            end else begin
                lookupValid = 1'b0;
            end
            @(negedge clk);
        end
        update0     = '0;
        update1     = '0;
        lookupValid = 1'b0;
        repeat (4) @(negedge clk);

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* sources.f */
+incdir+tb
verilog/ghtPkg.sv
verilog/ghtIndexHash.sv
verilog/ghtBank.sv
verilog/ghtWriteArbiter.sv
verilog/ghtPredictSelect.sv
verilog/ghtPredictor.sv
tb/ghtPredictorTb.sv

/* Bender.yml */
package:
  name: ghtPredictor

sources:
  - files:
      - verilog/ghtPkg.sv
      - verilog/ghtIndexHash.sv
      - verilog/ghtBank.sv
      - verilog/ghtWriteArbiter.sv
      - verilog/ghtPredictSelect.sv
      - verilog/ghtPredictor.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/ghtPredictorTb.sv
